/* cache_sys.f */
+incdir+include
design/mem_bus_pkg.sv
design/cache_geom_pkg.sv
design/cache_ctrl_fsm.sv
design/burst_counter.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/access_counters.sv
design/main_memory.sv
design/cache_subsystem.sv
test/cache_tb.sv

/* test/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb
	import mem_bus_pkg::*;
	import cache_geom_pkg::*;
();

	localparam int N_OPS      = 400;
	localparam int OP_CYCLES  = 40;                       // Worst case of dirty write-back and refill
	localparam int MAX_CYCLES = N_OPS * OP_CYCLES + 4000; // Margin for reset and idle gaps
	localparam int N_TAGS     = 5;                        // More tags than ways per set
	localparam int WIDX_BITS  = $clog2(`MEM_WORDS);

	logic     clk;
	logic     resetn;
	logic     cpu_valid;
	bus_req_t cpu_req;
	logic     cpu_ready;
	word_t    cpu_rdata;
	word_t    hit_count;
	word_t    miss_count;

	logic [31:0] rng_state   = 32'hd621_9d19;
	int          cycle_count = 0;

	word_t model_mem   [`MEM_WORDS];              // Byte-merged memory image
	strb_t model_known [`MEM_WORDS];              // Lanes written so far
	logic  model_valid [`CACHE_SETS][`CACHE_WAYS];
	tag_t  model_tag   [`CACHE_SETS][`CACHE_WAYS];
	way_t  model_lru   [`CACHE_SETS];             // LRU way of each set
	word_t model_hits;
	word_t model_misses;

	cache_subsystem uut (
		.clk(clk), .resetn(resetn),
		.cpu_valid(cpu_valid), .cpu_req(cpu_req),
		.cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
		.hit_count(hit_count), .miss_count(miss_count)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	// Run limit over the whole test
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: no cpu_ready arrived within %0d cycles", MAX_CYCLES);
			$display("tests failed");
			$fatal(1, "Run limit reached");
		end
	end

	function logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223; // LCG step
		return rng_state;
	endfunction

	// Few sets with several tags each so victims are often dirty
	function automatic addr_t make_addr(logic [31:0] r);
		index_t  idx;
		tag_t    tg;
		offset_t off;
		case (r[31:28] % 3)
			0:       idx = 4'd1;
			1:       idx = 4'd6;
			default: idx = 4'd13;
		endcase
		tg  = tag_t'(r[27:20] % N_TAGS);
		off = r[19:18];
		return {tg, idx, off, 2'b00};
	endfunction

	function automatic word_t lane_mask(strb_t lanes);
		word_t m;
		for (int b = 0; b < `STRB_BITS; b++)
			m[8*b +: 8] = {8{lanes[b]}};
		return m;
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		assert (actual === expected) else begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			$display("tests failed");
			$fatal(1, "Mismatch");
		end
	endtask

	// Two-way LRU with empty way first over a byte-merged memory
	task automatic model_access(input bus_req_t req, output logic was_hit);
		index_t idx;
		tag_t   tg;
		way_t   way;
		int     widx;
		idx     = req.addr[2+OFFSET_BITS +: INDEX_BITS];
		tg      = req.addr[2+OFFSET_BITS+INDEX_BITS +: TAG_BITS];
		widx    = req.addr[2 +: WIDX_BITS];
		was_hit = 1'b0;
		way     = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (model_valid[idx][w] && model_tag[idx][w] == tg) begin
				was_hit = 1'b1;
				way     = way_t'(w);
			end
		end
		if (was_hit) begin
			model_hits = model_hits + 1;
		end else begin
			if (!model_valid[idx][0])
				way = way_t'(0);
			else if (!model_valid[idx][1])
				way = way_t'(1);
			else
				way = model_lru[idx];
			model_valid[idx][way] = 1'b1;
			model_tag[idx][way]   = tg;
			model_misses          = model_misses + 1;
		end
		model_lru[idx] = ~way; // Other way is now least recent
		for (int b = 0; b < `STRB_BITS; b++) begin
			if (req.wstrb[b]) begin
				model_mem[widx][8*b +: 8] = req.wdata[8*b +: 8];
				model_known[widx][b]      = 1'b1;
			end
		end
	endtask

	task automatic run_op(input bus_req_t req, input logic expect_hit, input int n);
		int    waits;
		int    widx;
		word_t mask;
		widx = req.addr[2 +: WIDX_BITS];
		@(posedge clk);
		cpu_valid <= 1'b1;
		cpu_req   <= req;
		@(negedge clk);
		waits = 1;
		while (!cpu_ready) begin // Request held until the ready pulse
			@(negedge clk);
			waits++;
		end
		if (expect_hit)
			check_value($sformatf("op %0d hit latency", n), 32'd2, waits - 1);
		if (req.wstrb == '0) begin
			mask = lane_mask(model_known[widx]); // Unwritten lanes hold no known value
			check_value($sformatf("op %0d read data", n), model_mem[widx] & mask,
				cpu_rdata & mask);
		end
		check_value($sformatf("op %0d hit_count", n), model_hits, hit_count);
		check_value($sformatf("op %0d miss_count", n), model_misses, miss_count);
		@(posedge clk);
		cpu_valid <= 1'b0;
		@(negedge clk);
		check_value($sformatf("op %0d ready pulse width", n), 32'd0, {31'd0, cpu_ready});
	endtask

	initial begin
		bus_req_t    req;
		logic        hit_expected;
		logic [31:0] r;
		resetn       = 1'b0;
		cpu_valid    = 1'b0;
		cpu_req      = '0;
		model_hits   = '0;
		model_misses = '0;
		for (int i = 0; i < `MEM_WORDS; i++) begin
			model_mem[i]   = '0;
			model_known[i] = '0;
		end
		for (int s = 0; s < `CACHE_SETS; s++) begin
			model_lru[s] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w]   = '0;
			end
		end
		repeat (10) @(posedge clk);
		resetn <= 1'b1;
		@(negedge clk);
		check_value("reset cpu_ready", 32'd0, {31'd0, cpu_ready});
		check_value("reset hit_count", 32'd0, hit_count);
		check_value("reset miss_count", 32'd0, miss_count);
		for (int n = 0; n < N_OPS; n++) begin
			req.addr  = make_addr(next_random());
			r         = next_random();
			req.wdata = next_random();
			case (r[31:16] % 3)
				0:       req.wstrb = '0;                             // Read
				1:       req.wstrb = '1;                             // Full write
				default: req.wstrb = strb_t'(1 + int'(r[15:0]) % 14); // Partial write
			endcase
			model_access(req, hit_expected);
			run_op(req, hit_expected, n);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

/* design/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem
	import mem_bus_pkg::*;
	import cache_geom_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     cpu_valid,
	input  bus_req_t cpu_req,
	output logic     cpu_ready,
	output word_t    cpu_rdata,
	output word_t    hit_count,
	output word_t    miss_count
);

	logic     mem_valid, mem_ready;
	bus_req_t mem_req;
	word_t    mem_rdata;
	index_t   req_index;
	tag_t     req_tag, victim_tag;
	logic     hit, victim_dirty;
	way_t     hit_way, victim_way, tag_way, data_way;
	logic     tag_fill, tag_dirty, tag_touch;
	offset_t  data_word, burst_word;
	logic     data_we;
	strb_t    data_wstrb;
	word_t    data_wdata, rd_word;
	logic     burst_clear, burst_step, burst_last;
	logic     hit_evt, miss_evt;

	cache_ctrl_fsm u_ctrl (
		.clk(clk), .resetn(resetn),
		.cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready), .cpu_rdata(cpu_rdata),
		.mem_valid(mem_valid), .mem_req(mem_req), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.victim_dirty(victim_dirty), .victim_tag(victim_tag),
		.req_index(req_index), .req_tag(req_tag),
		.tag_fill(tag_fill), .tag_dirty(tag_dirty), .tag_touch(tag_touch), .tag_way(tag_way),
		.data_way(data_way), .data_word(data_word), .data_we(data_we),
		.data_wstrb(data_wstrb), .data_wdata(data_wdata), .rd_word(rd_word),
		.burst_clear(burst_clear), .burst_step(burst_step),
		.burst_word(burst_word), .burst_last(burst_last),
		.hit_evt(hit_evt), .miss_evt(miss_evt)
	);

	burst_counter u_burst (
		.clk(clk), .resetn(resetn), .clear(burst_clear), .step(burst_step),
		.word(burst_word), .last(burst_last)
	);

	cache_tag_store u_tags (
		.clk(clk), .resetn(resetn), .index(req_index), .tag(req_tag),
		.fill(tag_fill), .mark_dirty(tag_dirty), .touch(tag_touch), .way(tag_way),
		.hit(hit), .hit_way(hit_way), .victim_way(victim_way),
		.victim_dirty(victim_dirty), .victim_tag(victim_tag)
	);

	cache_data_store u_data (
		.clk(clk), .way(data_way), .index(req_index), .word(data_word),
		.we(data_we), .wstrb(data_wstrb), .wdata(data_wdata), .rdata(rd_word)
	);

	access_counters u_counters (
		.clk(clk), .resetn(resetn), .hit_evt(hit_evt), .miss_evt(miss_evt),
		.hit_count(hit_count), .miss_count(miss_count)
	);

	main_memory u_mem (
		.clk(clk), .resetn(resetn), .mem_valid(mem_valid), .mem_req(mem_req),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

endmodule

/* design/main_memory.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module main_memory
	import mem_bus_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     mem_valid,
	input  bus_req_t mem_req,
	output logic     mem_ready,
	output word_t    mem_rdata
);

	localparam int IDX_BITS  = $clog2(`MEM_WORDS);
	localparam int WAIT_BITS = $clog2(`MEM_WAIT + 1);

	word_t                mem [`MEM_WORDS];
	logic                 busy;       // Request accepted, timer running
	logic [WAIT_BITS-1:0] wait_cnt;
	logic [IDX_BITS-1:0]  idx;

	assign idx = mem_req.addr[2 +: IDX_BITS]; // Word address modulo memory size

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy      <= 1'b0;
			wait_cnt  <= '0;
			mem_ready <= 1'b0;
		end else begin
			mem_ready <= 1'b0;
			if (!busy && mem_valid && !mem_ready) begin
				busy     <= 1'b1;
				wait_cnt <= WAIT_BITS'(`MEM_WAIT - 1);
			end else if (busy) begin
				if (wait_cnt == 1) begin
					busy      <= 1'b0;
					mem_ready <= 1'b1; // Single pulse per request
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (busy && wait_cnt == 1) begin
			mem_rdata <= mem[idx]; // Data lines up with the ready pulse
			for (int b = 0; b < `STRB_BITS; b++) begin
				if (mem_req.wstrb[b])
					mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
			end
		end
	end

endmodule

/* design/access_counters.sv */
`timescale 1ns/1ps

module access_counters
	import mem_bus_pkg::*;
(
	input  logic  clk,
	input  logic  resetn,
	input  logic  hit_evt,
	input  logic  miss_evt,
	output word_t hit_count,
	output word_t miss_count
);

	// One pulse per lookup, counts wrap on overflow
	always_ff @(posedge clk) begin
		if (!resetn) begin
			hit_count  <= '0;
			miss_count <= '0;
		end else begin
			if (hit_evt)
				hit_count <= hit_count + 1'b1;
			if (miss_evt)
				miss_count <= miss_count + 1'b1;
		end
	end

endmodule

/* design/cache_data_store.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_data_store
	import mem_bus_pkg::*;
	import cache_geom_pkg::*;
(
	input  logic    clk,
	input  way_t    way,
	input  index_t  index,
	input  offset_t word,
	input  logic    we,
	input  strb_t   wstrb,
	input  word_t   wdata,
	output word_t   rdata
);

	word_t data_mem [`CACHE_WAYS][`CACHE_SETS][`CACHE_BLOCK_WORDS];

	assign rdata = data_mem[way][index][word]; // Asynchronous read

	// Only the enabled byte lanes change
	always_ff @(posedge clk) begin
		if (we) begin
			for (int b = 0; b < `STRB_BITS; b++) begin
				if (wstrb[b])
					data_mem[way][index][word][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

endmodule

/* design/cache_tag_store.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tag_store
	import cache_geom_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  index_t index,
	input  tag_t   tag,
	input  logic   fill,
	input  logic   mark_dirty,
	input  logic   touch,
	input  way_t   way,
	output logic   hit,
	output way_t   hit_way,
	output way_t   victim_way,
	output logic   victim_dirty,
	output tag_t   victim_tag
);

	tag_t tag_mem   [`CACHE_SETS][`CACHE_WAYS];
	logic valid_mem [`CACHE_SETS][`CACHE_WAYS];
	logic dirty_mem [`CACHE_SETS][`CACHE_WAYS];
	way_t lru_mem   [`CACHE_SETS];          // Least recently used way of each set

	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (valid_mem[index][w] && tag_mem[index][w] == tag) begin
				hit     = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	// Empty way first, else the LRU way
	always_comb begin
		if (!valid_mem[index][0])
			victim_way = way_t'(0);
		else if (!valid_mem[index][1])
			victim_way = way_t'(1);
		else
			victim_way = lru_mem[index];
	end

	assign victim_dirty = dirty_mem[index][victim_way];
	assign victim_tag   = tag_mem[index][victim_way];   // Write-back address

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				lru_mem[s] <= '0;
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					tag_mem[s][w]   <= '0;
					valid_mem[s][w] <= 1'b0;
					dirty_mem[s][w] <= 1'b0;
				end
			end
		end else begin
			if (fill) begin
				tag_mem[index][way]   <= tag;
				valid_mem[index][way] <= 1'b1;
				dirty_mem[index][way] <= mark_dirty; // Clean unless written in the same cycle
			end else if (mark_dirty) begin
				dirty_mem[index][way] <= 1'b1;
			end
			if (touch)
				lru_mem[index] <= ~way; // Other way becomes LRU
		end
	end

endmodule

/* design/burst_counter.sv */
`timescale 1ns/1ps

module burst_counter
	import cache_geom_pkg::*;
(
	input  logic    clk,
	input  logic    resetn,
	input  logic    clear,
	input  logic    step,
	output offset_t word,
	output logic    last
);

	always_ff @(posedge clk) begin
		if (!resetn)
			word <= '0;
		else if (clear)
			word <= '0;      // Start of a new burst
		else if (step)
			word <= word + 1'b1; // Wraps after the last word
	end

	assign last = (word == '1); // Final word of the block

endmodule

/* design/cache_ctrl_fsm.sv */
`timescale 1ns/1ps

module cache_ctrl_fsm
	import mem_bus_pkg::*;
	import cache_geom_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     cpu_valid,
	input  bus_req_t cpu_req,
	output logic     cpu_ready,
	output word_t    cpu_rdata,
	output logic     mem_valid,
	output bus_req_t mem_req,
	input  logic     mem_ready,
	input  word_t    mem_rdata,
	input  logic     hit,
	input  way_t     hit_way,
	input  way_t     victim_way,
	input  logic     victim_dirty,
	input  tag_t     victim_tag,
	output index_t   req_index,
	output tag_t     req_tag,
	output logic     tag_fill,
	output logic     tag_dirty,
	output logic     tag_touch,
	output way_t     tag_way,
	output way_t     data_way,
	output offset_t  data_word,
	output logic     data_we,
	output strb_t    data_wstrb,
	output word_t    data_wdata,
	input  word_t    rd_word,
	output logic     burst_clear,
	output logic     burst_step,
	input  offset_t  burst_word,
	input  logic     burst_last,
	output logic     hit_evt,
	output logic     miss_evt
);

	ctrl_state_t state, state_nxt;
	bus_req_t    req_q;     // Latched processor request
	way_t        way_q;     // Way that serves the request
	logic        miss_q;    // Request missed, new tag to commit
	offset_t     req_word;
	logic        req_write;

	assign req_word  = req_q.addr[2 +: OFFSET_BITS];
	assign req_index = req_q.addr[2+OFFSET_BITS +: INDEX_BITS];
	assign req_tag   = req_q.addr[2+OFFSET_BITS+INDEX_BITS +: TAG_BITS];
	assign req_write = |req_q.wstrb;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:      if (cpu_valid) state_nxt = LOOKUP;
			LOOKUP: begin
				if (hit)
					state_nxt = RESPOND;
				else if (victim_dirty)
					state_nxt = WRITEBACK; // Victim must go out first
				else
					state_nxt = REFILL;
			end
			WRITEBACK: if (mem_ready && burst_last) state_nxt = REFILL;
			REFILL:    if (mem_ready && burst_last) state_nxt = RESPOND;
			RESPOND:   state_nxt = IDLE;
			default:   state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= IDLE;
			mem_valid <= 1'b0;
			miss_q    <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == LOOKUP)
				miss_q <= !hit;
			// One idle cycle between words of a burst
			if ((state == WRITEBACK || state == REFILL) && state_nxt == state)
				mem_valid <= mem_valid ? !mem_ready : 1'b1;
			else
				mem_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && cpu_valid)
			req_q <= cpu_req;
		if (state == LOOKUP)
			way_q <= hit ? hit_way : victim_way; // Refill lands in the victim
	end

	assign cpu_ready = (state == RESPOND);
	assign cpu_rdata = rd_word;
	assign hit_evt   = (state == LOOKUP) && hit;
	assign miss_evt  = (state == LOOKUP) && !hit;

	assign burst_clear = (state == LOOKUP);
	assign burst_step  = mem_valid && mem_ready; // One word done

	assign tag_fill  = (state == RESPOND) && miss_q;
	assign tag_dirty = (state == RESPOND) && req_write;
	assign tag_touch = (state == RESPOND);
	assign tag_way   = way_q;

	assign data_way   = way_q;
	assign data_word  = (state == RESPOND) ? req_word : burst_word;
	assign data_we    = (state == REFILL && mem_ready) || (state == RESPOND && req_write);
	assign data_wstrb = (state == REFILL) ? '1 : req_q.wstrb;
	assign data_wdata = (state == REFILL) ? mem_rdata : req_q.wdata;

	always_comb begin
		mem_req.addr  = {(state == WRITEBACK) ? victim_tag : req_tag, req_index, burst_word, 2'b00};
		mem_req.wdata = rd_word;                          // Victim word during write-back
		mem_req.wstrb = (state == WRITEBACK) ? '1 : '0;   // Refill reads
	end

endmodule

/* design/cache_geom_pkg.sv */
`include "cache_consts.svh"

package cache_geom_pkg;

	localparam int OFFSET_BITS = $clog2(`CACHE_BLOCK_WORDS);
	localparam int INDEX_BITS  = $clog2(`CACHE_SETS);
	localparam int WAY_BITS    = $clog2(`CACHE_WAYS);
	localparam int TAG_BITS    = `ADDR_BITS - INDEX_BITS - OFFSET_BITS - 2; // Above index, offset, byte

	typedef logic [OFFSET_BITS-1:0] offset_t; // Word within a block
	typedef logic [INDEX_BITS-1:0]  index_t;  // Set number
	typedef logic [TAG_BITS-1:0]    tag_t;    // Upper address bits
	typedef logic [WAY_BITS-1:0]    way_t;    // Way number

	// Controller sequence for one request
	typedef enum logic [2:0] {
		IDLE,      // Wait for a request
		LOOKUP,    // Compare tags
		WRITEBACK, // Dirty victim out to memory
		REFILL,    // Missed block in from memory
		RESPOND    // Serve the request
	} ctrl_state_t;

endpackage

/* design/mem_bus_pkg.sv */
`include "cache_consts.svh"

package mem_bus_pkg;

	typedef logic [`ADDR_BITS-1:0] addr_t; // Byte address
	typedef logic [`WORD_BITS-1:0] word_t; // Data word
	typedef logic [`STRB_BITS-1:0] strb_t; // Byte lane enables, zero for a read

	// One request on the processor or memory side
	typedef struct packed {
		addr_t addr;  // Byte address, word aligned
		word_t wdata; // Write data
		strb_t wstrb; // Lanes to write
	} bus_req_t;

endpackage

/* include/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Cache geometry
`define CACHE_SETS        16
`define CACHE_WAYS        2
`define CACHE_BLOCK_WORDS 4

// Main memory model
`define MEM_WORDS         1024
`define MEM_WAIT          2    // Cycles from sampled request to ready, at least 2

// Bus widths
`define ADDR_BITS         32
`define WORD_BITS         32
`define STRB_BITS         4

`endif
